// File: uart_bridge.f
src/uart_line_pkg.sv
src/uart_cmd_pkg.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_cmd_seq.sv
src/uart_bridge.sv
verification/tb_clk_gen.sv
verification/tb_uart_peer.sv
verification/tb_uart_bridge.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_uart_bridge
FILELIST  = uart_bridge.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_uart_bridge.sv
module tb_uart_bridge
  import uart_line_pkg::*, uart_cmd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int wait_limit = 1000;
  localparam int num_writes = 6;

  logic clk;
  logic rst_n;
  cmd_t cmd;
  logic cmd_valid;
  logic cmd_ready;
  rsp_t rsp;
  logic rsp_valid;
  logic rsp_ready;
  logic tx;
  logic rx;
  logic flip_parity;
  logic bad_stop;
  logic silent;

  int         seed;
  int         mismatches;
  int         timeouts;
  logic [6:0] wr_addr [$];
  logic [7:0] wr_data [$];

  tb_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

  uart_bridge dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .tx       (tx),
    .rx       (rx)
  );

  tb_uart_peer peer0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .rx         (rx),
    .flip_parity(flip_parity),
    .bad_stop   (bad_stop),
    .silent     (silent)
  );

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("gave up waiting for %s after %0d cycles at %0t ns", what, wait_limit, $time);
  endtask

  // all tasks start and end on a falling edge
  task automatic issue_cmd(input logic rw, input logic [6:0] a, input logic [7:0] d);
    int n;
    n = 0;
    cmd.rw = rw;
    cmd.addr = a;
    cmd.data = d;
    cmd_valid = 1'b1;
    while (!cmd_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ready) begin
      report_timeout("cmd_ready before a command");
    end else begin
      @(negedge clk);
      if (cmd_ready) report_mismatch("cmd_ready still high after accept");
    end
    cmd_valid = 1'b0;
  endtask

  task automatic take_rsp(output logic ok, output rsp_t r);
    int n;
    n = 0;
    while (!rsp_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    ok = rsp_valid;
    r = rsp;
    if (!ok) begin
      report_timeout("rsp_valid");
    end else begin
      rsp_ready = 1'b1;
      @(negedge clk);
      rsp_ready = 1'b0;
      if (rsp_valid) report_mismatch("rsp_valid still high after transfer");
      if (!cmd_ready) report_mismatch("cmd_ready low after response");
    end
  endtask

  task automatic write_check(input logic [6:0] a, input logic [7:0] d);
    int first;
    int n;
    first = peer0.log_byte.size();
    issue_cmd(1'b0, a, d);
    n = 0;
    while (!cmd_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ready) report_timeout("cmd_ready after a write");
    if (peer0.log_byte.size() != first + 2) begin
      report_mismatch($sformatf("write to %02h gave %0d frames, expected 2",
                                a, peer0.log_byte.size() - first));
    end else begin
      if (peer0.log_byte[first] !== {1'b0, a}) begin
        report_mismatch($sformatf("address frame %02h, expected %02h",
                                  peer0.log_byte[first], {1'b0, a}));
      end
      if (peer0.log_byte[first + 1] !== d) begin
        report_mismatch($sformatf("data frame %02h, expected %02h",
                                  peer0.log_byte[first + 1], d));
      end
      if (!(peer0.log_par_ok[first] && peer0.log_par_ok[first + 1] &&
            peer0.log_stop_ok[first] && peer0.log_stop_ok[first + 1])) begin
        report_mismatch($sformatf("bad parity or stop bit in write to %02h", a));
      end
    end
  endtask

  task automatic read_check(input logic [6:0] a, input logic [7:0] exp_data,
                            input logic pe, input logic fe, input logic to);
    rsp_t r;
    logic ok;
    issue_cmd(1'b1, a, 8'h00);
    take_rsp(ok, r);
    if (ok) begin
      if (r.data !== exp_data) begin
        report_mismatch($sformatf("read of %02h gave %02h, expected %02h", a, r.data, exp_data));
      end
      if ({r.parity_err, r.frame_err, r.timeout} !== {pe, fe, to}) begin
        report_mismatch($sformatf("read of %02h gave flags %03b, expected %03b",
                                  a, {r.parity_err, r.frame_err, r.timeout}, {pe, fe, to}));
      end
    end
    // let the peer finish its reply frame
    repeat (4 * clks_per_bit) @(negedge clk);
  endtask

  task automatic write_random_regs();
    logic [6:0] base;
    logic [6:0] a;
    logic [7:0] d;
    base = 7'($random(seed));
    for (int i = 0; i < num_writes; i++) begin
      a = base + 7'(i * 19);
      d = 8'($random(seed));
      write_check(a, d);
      wr_addr.push_back(a);
      wr_data.push_back(d);
    end
  endtask

  task automatic verify_readback();
    for (int i = 0; i < wr_addr.size(); i++) begin
      read_check(wr_addr[i], wr_data[i], 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic parity_fault_read();
    flip_parity = 1'b1;
    read_check(wr_addr[0], wr_data[0], 1'b1, 1'b0, 1'b0);
    flip_parity = 1'b0;
  endtask

  task automatic stop_fault_and_silence();
    logic [7:0] d;
    bad_stop = 1'b1;
    read_check(wr_addr[1], wr_data[1], 1'b0, 1'b1, 1'b0);
    bad_stop = 1'b0;
    silent = 1'b1;
    read_check(wr_addr[2], 8'h00, 1'b0, 1'b0, 1'b1);
    silent = 1'b0;
    // bridge must take new work after a timeout
    d = 8'($random(seed));
    write_check(wr_addr[3], d);
    wr_data[3] = d;
  endtask

  task automatic hold_off_response();
    rsp_t snap;
    rsp_t r;
    logic ok;
    int   hold;
    int   extra;
    hold = 20 + (($random(seed) & 32'h7fff_ffff) % 181);
    extra = 0;
    issue_cmd(1'b1, wr_addr[3], 8'h00);
    while (!rsp_valid && extra < wait_limit) begin
      @(negedge clk);
      extra++;
    end
    if (!rsp_valid) begin
      report_timeout("rsp_valid under back-pressure");
    end else begin
      snap = rsp;
      for (int k = 0; k < hold; k++) begin
        @(negedge clk);
        if (!rsp_valid) report_mismatch("rsp_valid dropped while rsp_ready low");
        if (rsp !== snap) report_mismatch("rsp changed while rsp_ready low");
        if (cmd_ready) report_mismatch("cmd_ready high during back-pressure");
      end
      take_rsp(ok, r);
      if (r !== snap) report_mismatch("delivered rsp differs from held rsp");
      if (r.data !== wr_data[3] || r.parity_err || r.frame_err || r.timeout) begin
        report_mismatch($sformatf("held read gave %02h flags %03b, expected %02h flags 000",
                                  r.data, {r.parity_err, r.frame_err, r.timeout}, wr_data[3]));
      end
      extra = 0;
      for (int k = 0; k < 20; k++) begin
        @(negedge clk);
        if (rsp_valid) extra++;
      end
      if (extra != 0) report_mismatch("response delivered more than once");
    end
  endtask

  initial begin
    int n;
    seed = 32'h5b25_4f45;
    mismatches = 0;
    timeouts = 0;
    cmd = '0;
    cmd_valid = 1'b0;
    rsp_ready = 1'b0;
    flip_parity = 1'b0;
    bad_stop = 1'b0;
    silent = 1'b0;
    n = 0;
    while (rst_n !== 1'b1 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) report_timeout("reset release");
    @(negedge clk);
    if (tx !== 1'b1 || cmd_ready !== 1'b1 || rsp_valid !== 1'b0) begin
      report_mismatch("idle state after reset wrong");
    end
    write_random_regs();
    verify_readback();
    parity_fault_read();
    stop_fault_and_silence();
    hold_off_response();
    $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/tb_uart_peer.sv
module tb_uart_peer
  import uart_line_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  output logic rx,
  input  logic flip_parity,
  input  logic bad_stop,
  input  logic silent
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] regs [0:127];
  logic [7:0] log_byte [$];
  logic       log_par_ok [$];
  logic       log_stop_ok [$];

  // line sampled on falling edges, bits land LSB first in got
  task automatic receive_frame(output logic [9:0] got);
    logic found;
    found = 1'b0;
    got = '0;
    while (!found) begin
      while (!(rst_n === 1'b1 && tx === 1'b0)) begin
        @(negedge clk);
      end
      // middle of the start bit
      repeat (clks_per_bit / 2) @(negedge clk);
      found = (tx === 1'b0);
    end
    for (int i = 1; i < frame_bits; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      got = {tx, got[9:1]};
    end
  endtask

  task automatic send_frame(input logic [7:0] data);
    logic [frame_bits-1:0] bits;
    bits = {~bad_stop, (~^data) ^ flip_parity, data, 1'b0};
    for (int i = 0; i < frame_bits; i++) begin
      rx = bits[0];
      bits = bits >> 1;
      repeat (clks_per_bit) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  initial begin
    logic [9:0] got;
    logic       want_data;
    logic [6:0] wr_addr;
    rx = 1'b1;
    regs = '{default: 8'h00};
    want_data = 1'b0;
    wr_addr = '0;
    forever begin
      receive_frame(got);
      log_byte.push_back(got[7:0]);
      log_par_ok.push_back(^got[8:0]);
      log_stop_ok.push_back(got[9]);
      if (want_data) begin
        regs[wr_addr] = got[7:0];
        want_data = 1'b0;
      end else if (got[7]) begin
        // read request, reply after two bit periods
        repeat (2 * clks_per_bit) @(negedge clk);
        if (!silent) send_frame(regs[got[6:0]]);
      end else begin
        wr_addr = got[6:0];
        want_data = 1'b1;
      end
    end
  end

endmodule

// File: verification/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for four rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: src/uart_bridge.sv
module uart_bridge
  import uart_line_pkg::*, uart_cmd_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  cmd_t cmd,
  input  logic cmd_valid,
  output logic cmd_ready,
  output rsp_t rsp,
  output logic rsp_valid,
  input  logic rsp_ready,
  output logic tx,
  input  logic rx
);

  line_byte_t tx_byte;
  logic       tx_valid;
  logic       tx_ready;
  rx_frame_t  rx_frame;
  logic       rx_valid;
  logic       rx_busy;

  uart_cmd_seq u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .rx_frame (rx_frame),
    .rx_valid (rx_valid),
    .rx_busy  (rx_busy)
  );

  uart_tx_frame u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .tx      (tx)
  );

  uart_rx_frame u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_frame(rx_frame),
    .rx_valid(rx_valid),
    .rx_busy (rx_busy)
  );

endmodule

// File: src/uart_cmd_seq.sv
module uart_cmd_seq
  import uart_line_pkg::*, uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  output rsp_t       rsp,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output line_byte_t tx_byte,
  output logic       tx_valid,
  input  logic       tx_ready,
  input  rx_frame_t  rx_frame,
  input  logic       rx_valid,
  input  logic       rx_busy
);

  localparam int timeout_cycles = reply_timeout_bits * clks_per_bit;
  localparam int tmr_w = $clog2(timeout_cycles);
  localparam logic [tmr_w-1:0] tmr_last = tmr_w'(timeout_cycles - 1);

  seq_state_e       state;
  cmd_t             cmd_q;
  rsp_t             rsp_q;
  logic             tx_sent;
  logic             frame_done;
  logic             cmd_accept;
  logic             timeout_hit;
  logic [tmr_w-1:0] tmr;

  assign cmd_ready = (state == idle);
  assign rsp_valid = (state == hold_rsp);
  assign rsp       = rsp_q;

  assign cmd_accept = cmd_valid && cmd_ready;

  // byte handed over once, then wait for the transmitter to go idle
  assign tx_valid   = (state == send_addr || state == send_data) && !tx_sent;
  assign tx_byte    = (state == send_data) ? cmd_q.data : {cmd_q.rw, cmd_q.addr};
  assign frame_done = tx_sent && tx_ready;

  // timer only runs while no reply frame is in flight
  assign timeout_hit = (state == wait_reply) && !rx_valid && !rx_busy && (tmr == tmr_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      tx_sent <= 1'b0;
      tmr     <= '0;
    end else begin
      case (state)
        idle: begin
          if (cmd_accept) begin
            state   <= send_addr;
            tx_sent <= 1'b0;
          end
        end
        send_addr: begin
          if (tx_valid && tx_ready) begin
            tx_sent <= 1'b1;
          end else if (frame_done) begin
            tx_sent <= 1'b0;
            if (cmd_q.rw) begin
              state <= wait_reply;
              tmr   <= '0;
            end else begin
              state <= send_data;
            end
          end
        end
        send_data: begin
          if (tx_valid && tx_ready) begin
            tx_sent <= 1'b1;
          end else if (frame_done) begin
            tx_sent <= 1'b0;
            state   <= idle;
          end
        end
        wait_reply: begin
          if (rx_valid || timeout_hit) begin
            state <= hold_rsp;
          end else if (!rx_busy) begin
            tmr <= tmr + 1'b1;
          end
        end
        hold_rsp: begin
          if (rsp_ready) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      cmd_q <= cmd;
    end
    if (state == wait_reply && rx_valid) begin
      rsp_q <= '{data: rx_frame.data, parity_err: rx_frame.parity_err,
                 frame_err: rx_frame.frame_err, timeout: 1'b0};
    end else if (timeout_hit) begin
      rsp_q <= '{data: '0, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
    end
  end

  a_ready_rsp_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cmd_ready && rsp_valid)
  );

  // response held under back-pressure
  a_rsp_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
  );

endmodule

// File: src/uart_rx_frame.sv
module uart_rx_frame
  import uart_line_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rx,
  output rx_frame_t rx_frame,
  output logic      rx_valid,
  output logic      rx_busy
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [cnt_w-1:0] full_last = cnt_w'(clks_per_bit - 1);
  localparam logic [3:0] parity_idx = 4'(frame_bits - 2);
  localparam logic [3:0] stop_idx = 4'(frame_bits - 1);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;
  logic             sample;
  logic [cnt_w-1:0] bit_cnt;
  logic [3:0]       bit_idx;
  line_byte_t       shift_q;
  logic             parity_q;

  // two flop synchroniser plus edge history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev & ~rx_sync & ~rx_busy;

  // start bit is checked half a period in, the rest a full period apart
  assign sample = rx_busy && (bit_cnt == ((bit_idx == 4'd0) ? half_last : full_last));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy  <= 1'b0;
      rx_valid <= 1'b0;
      bit_cnt  <= '0;
      bit_idx  <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (fall) begin
        rx_busy <= 1'b1;
        bit_cnt <= '0;
        bit_idx <= '0;
      end else if (sample) begin
        bit_cnt <= '0;
        if (bit_idx == 4'd0 && rx_sync) begin
          // glitch, start bit gone at midpoint
          rx_busy <= 1'b0;
        end else if (bit_idx == stop_idx) begin
          rx_busy  <= 1'b0;
          rx_valid <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else if (rx_busy) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_idx == parity_idx) begin
        parity_q <= rx_sync;
      end else if (bit_idx == stop_idx) begin
        rx_frame.data       <= shift_q;
        // odd parity expected over data and parity bit
        rx_frame.parity_err <= ~^{shift_q, parity_q};
        rx_frame.frame_err  <= ~rx_sync;
      end else if (bit_idx != 4'd0) begin
        shift_q <= {rx_sync, shift_q[7:1]};
      end
    end
  end

  a_valid_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid
  );

endmodule

// File: src/uart_tx_frame.sv
module uart_tx_frame
  import uart_line_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  line_byte_t tx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       tx
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
  localparam logic [3:0] idx_last = 4'(frame_bits - 1);

  logic [frame_bits-1:0] shift_q;
  logic [cnt_w-1:0]      bit_cnt;
  logic [3:0]            bit_idx;
  logic                  busy;

  assign tx_ready = ~busy;

  // line follows the low end of the shifter, which idles at all ones
  assign tx = shift_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      shift_q <= '1;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else if (tx_valid && tx_ready) begin
      // stop, odd parity, data, start
      busy    <= 1'b1;
      shift_q <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      bit_cnt <= '0;
      bit_idx <= '0;
    end else if (busy) begin
      if (bit_cnt == cnt_last) begin
        bit_cnt <= '0;
        shift_q <= {1'b1, shift_q[frame_bits-1:1]};
        if (bit_idx == idx_last) begin
          busy <= 1'b0;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // idle line is high
  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_ready |-> tx
  );

endmodule

// File: src/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // host command, rw set means read
  typedef struct packed {
    logic       rw;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // read response with line status
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
    logic       timeout;
  } rsp_t;

  typedef enum logic [2:0] {
    idle,
    send_addr,
    send_data,
    wait_reply,
    hold_rsp
  } seq_state_e;

endpackage

// File: src/uart_line_pkg.sv
package uart_line_pkg;

  // serial bit period in clock cycles, 4 or more
  localparam int clks_per_bit = 8;

  // start, eight data, odd parity, stop
  localparam int frame_bits = 11;

  // bit periods to wait for a reply start bit
  localparam int reply_timeout_bits = 40;

  typedef logic [7:0] line_byte_t;

  typedef struct packed {
    line_byte_t data;
    logic       parity_err;
    logic       frame_err;
  } rx_frame_t;

endpackage
